// File: hdl/wbx_pkg.sv
//--------------------------------------------------------------------------
// Wishbone error generator shared definitions
// bus widths, payload vector types and the response state encoding
//--------------------------------------------------------------------------

package wbx_pkg;

   //-----------------------------------------------------------------------
   // bus widths
   //-----------------------------------------------------------------------
   localparam int ADR_WIDTH   = 16;          // address bus
   localparam int DAT_WIDTH   = 16;          // read and write data buses
   localparam int SEL_WIDTH   = 2;           // one select per data byte
   localparam int OUTST_WIDTH = 4;           // up to 15 requests in flight

   //-----------------------------------------------------------------------
   // payload vectors
   //-----------------------------------------------------------------------
   typedef logic [ADR_WIDTH-1:0] wbx_adr_t;  // word address
   typedef logic [DAT_WIDTH-1:0] wbx_dat_t;  // data word
   typedef logic [SEL_WIDTH-1:0] wbx_sel_t;  // byte selects

   //-----------------------------------------------------------------------
   // response state
   //-----------------------------------------------------------------------
   // ST_IDLE   nothing outstanding
   // ST_BUSY   valid requests wait for their target response
   // ST_ERROR  generated err is on the initiator bus this cycle
   typedef enum logic [1:0]
   {
      ST_IDLE  = 2'b00,                      // reset value
      ST_BUSY  = 2'b01,                      // counter non-zero
      ST_ERROR = 2'b10                       // err pulse cycle
   } wbx_state_t;

endpackage : wbx_pkg

// File: hdl/wbx_req_if.sv
//--------------------------------------------------------------------------
// Wishbone initiator request bundle
// carries one pipelined request from the top level to the router
//--------------------------------------------------------------------------

`timescale 1ns/1ps

interface wbx_req_if
   import wbx_pkg::*;
#(
   parameter int TGT_CNT = 4                 // width of the target select tag
)
(
   input  logic clk_i                        // bus clock, sampled by checks
);

   logic               cyc;                  // bus cycle indicator
   logic               stb;                  // access request
   logic               we;                   // write enable
   wbx_sel_t           sel;                  // byte selects
   wbx_adr_t           adr;                  // address
   wbx_dat_t           dat;                  // write data
   logic [TGT_CNT-1:0] tgtsel;               // one-hot-ish target select

   // driven from the initiator ports
   modport src (
      output cyc, stb, we, sel, adr, dat, tgtsel
   );

   // consumed by the request router
   modport dst (
      input  clk_i,
      input  cyc, stb, we, sel, adr, dat, tgtsel
   );

endinterface : wbx_req_if

// File: hdl/wbx_req_router.sv
//--------------------------------------------------------------------------
// Wishbone request router
// sorts requests by target select, forwards the valid ones to the target
// and merges the target response with the generated error
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module wbx_req_router
   import wbx_pkg::*;
#(
   parameter int TGT_CNT = 4                 // width of the target select tag
)
(
   wbx_req_if.dst req,                       // initiator request

   // error FSM side
   input  logic     gen_err_i,               // generated err pulse
   input  logic     hold_inval_i,            // stall for invalid requests
   output logic     val_acc_o,               // valid request accepted
   output logic     inval_acc_o,             // invalid request accepted
   output logic     tgt_done_o,              // target response this cycle

   // target bus
   output logic     tgt_cyc_o,               // bus cycle indicator
   output logic     tgt_stb_o,               // access request
   output logic     tgt_we_o,                // write enable
   output wbx_sel_t tgt_sel_o,               // byte selects
   output wbx_adr_t tgt_adr_o,               // address
   output wbx_dat_t tgt_dat_o,               // write data
   input  logic     tgt_ack_i,               // acknowledge
   input  logic     tgt_err_i,               // error
   input  logic     tgt_rty_i,               // retry
   input  logic     tgt_stall_i,             // target back-pressure
   input  wbx_dat_t tgt_dat_i,               // read data

   // initiator response
   output logic     itr_ack_o,               // acknowledge
   output logic     itr_err_o,               // target or generated error
   output logic     itr_rty_o,               // retry
   output logic     itr_stall_o,             // back-pressure
   output wbx_dat_t itr_dat_o                // read data
);

   logic [TGT_CNT-1:0] tgtsel;               // local copy of the tag
   logic               valid;                // at least one target selected
   logic               req_act;              // cyc and stb both high
   logic               stall;                // selected stall source
   logic               accept;               // request taken this cycle

   //-----------------------------------------------------------------------
   // classification and acceptance
   //-----------------------------------------------------------------------
   assign tgtsel  = req.tgtsel;
   assign valid   = |tgtsel;                 // all-zero select is invalid
   assign req_act = req.cyc & req.stb;

   // target stall gates valid requests, the ordering hold gates invalid ones
   assign stall   = valid ? tgt_stall_i : hold_inval_i;
   assign accept  = req_act & ~stall;

   assign val_acc_o   = accept & valid;
   assign inval_acc_o = accept & ~valid;
   assign tgt_done_o  = tgt_ack_i | tgt_err_i | tgt_rty_i;

   //-----------------------------------------------------------------------
   // request path to the target
   //-----------------------------------------------------------------------
   assign tgt_cyc_o = req.cyc;               // cycle follows the initiator
   assign tgt_stb_o = req.stb & valid;       // invalid strobes never leave
   assign tgt_we_o  = req.we;
   assign tgt_sel_o = req.sel;
   assign tgt_adr_o = req.adr;
   assign tgt_dat_o = req.dat;

   //-----------------------------------------------------------------------
   // response path to the initiator
   //-----------------------------------------------------------------------
   assign itr_ack_o   = tgt_ack_i;
   assign itr_err_o   = tgt_err_i | gen_err_i;    // both error sources
   assign itr_rty_o   = tgt_rty_i;
   assign itr_stall_o = stall;
   assign itr_dat_o   = tgt_dat_i;

   // an unselected request must not reach the target, whatever the stalls do
   a_no_inval_stb : assert property (
      @(posedge req.clk_i) (req.cyc && !(|req.tgtsel)) |-> !tgt_stb_o
   ) else $error("strobe forwarded with empty target select");

endmodule : wbx_req_router

// File: hdl/wbx_err_fsm.sv
//--------------------------------------------------------------------------
// Wishbone error response FSM
// counts outstanding valid requests, holds invalid ones until the count
// drains, and answers each invalid request with a one-cycle err
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module wbx_err_fsm
   import wbx_pkg::*;
(
   input  logic clk_i,                       // bus clock
   input  logic rst_i,                       // async reset, active high

   input  logic val_acc_i,                   // valid request accepted
   input  logic inval_acc_i,                 // invalid request accepted
   input  logic tgt_done_i,                  // target ack, err or rty

   output logic gen_err_o,                   // generated err pulse
   output logic hold_inval_o                 // stall invalid requests
);

   wbx_state_t             state_q;          // current response state
   wbx_state_t             state_d;          // next response state
   logic [OUTST_WIDTH-1:0] outst_q;          // requests awaiting a response
   logic [OUTST_WIDTH-1:0] outst_d;          // next count

   //-----------------------------------------------------------------------
   // outstanding request counter
   //-----------------------------------------------------------------------
   always_comb
   begin
      outst_d = outst_q;                     // default hold
      case ({val_acc_i, tgt_done_i})
         2'b10:
         begin
            outst_d = outst_q + 1'b1;        // new request forwarded
         end
         2'b01:
         begin
            outst_d = outst_q - 1'b1;        // response returned
         end
         default:
         begin
            outst_d = outst_q;               // none, or one in and one out
         end
      endcase
   end

   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         outst_q <= '0;
      end
      else
      begin
         outst_q <= outst_d;
      end
   end

   //-----------------------------------------------------------------------
   // response state
   //-----------------------------------------------------------------------
   //   inval_acc       -> ST_ERROR  (err goes out next cycle)
   //   count non-zero  -> ST_BUSY
   //   otherwise       -> ST_IDLE
   always_comb
   begin
      if (inval_acc_i)
      begin
         state_d = ST_ERROR;                 // answer the invalid request
      end
      else if (outst_d != '0)
      begin
         state_d = ST_BUSY;                  // still waiting on the target
      end
      else
      begin
         state_d = ST_IDLE;
      end
   end

   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         state_q <= ST_IDLE;
      end
      else
      begin
         state_q <= state_d;
      end
   end

   assign gen_err_o    = (state_q == ST_ERROR);   // exactly one cycle
   assign hold_inval_o = (outst_q != '0);         // keeps responses in order

   //-----------------------------------------------------------------------
   // checks
   //-----------------------------------------------------------------------
   a_err_follows : assert property (
      @(posedge clk_i) disable iff (rst_i) inval_acc_i |=> gen_err_o
   ) else $error("no err the cycle after an invalid request");

   a_inval_ordered : assert property (
      @(posedge clk_i) disable iff (rst_i) inval_acc_i |-> (outst_q == '0)
   ) else $error("invalid request taken with responses outstanding");

   a_no_underflow : assert property (
      @(posedge clk_i) disable iff (rst_i)
         (tgt_done_i && !val_acc_i) |-> (outst_q != '0)
   ) else $error("target response without an outstanding request");

   a_no_overflow : assert property (
      @(posedge clk_i) disable iff (rst_i)
         (val_acc_i && !tgt_done_i) |-> (outst_q != '1)
   ) else $error("outstanding counter overflow");

endmodule : wbx_err_fsm

// File: hdl/wbx_error_generator.sv
//--------------------------------------------------------------------------
// Wishbone pipelined error generator
// passes requests with a target select to the target and answers requests
// without one with a single err cycle, keeping responses in order
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module wbx_error_generator
   import wbx_pkg::*;
#(
   parameter int TGT_CNT = 4                 // width of the target select tag
)
(
   input  logic               clk_i,         // bus clock
   input  logic               rst_i,         // async reset, active high

   // initiator bus
   input  logic               itr_cyc_i,     // bus cycle indicator
   input  logic               itr_stb_i,     // access request
   input  logic               itr_we_i,      // write enable
   input  wbx_sel_t           itr_sel_i,     // byte selects
   input  wbx_adr_t           itr_adr_i,     // address
   input  wbx_dat_t           itr_dat_i,     // write data
   input  logic [TGT_CNT-1:0] itr_tgtsel_i,  // target select tag
   output logic               itr_ack_o,     // acknowledge
   output logic               itr_err_o,     // error
   output logic               itr_rty_o,     // retry
   output logic               itr_stall_o,   // back-pressure
   output wbx_dat_t           itr_dat_o,     // read data

   // target bus
   output logic               tgt_cyc_o,     // bus cycle indicator
   output logic               tgt_stb_o,     // access request
   output logic               tgt_we_o,      // write enable
   output wbx_sel_t           tgt_sel_o,     // byte selects
   output wbx_adr_t           tgt_adr_o,     // address
   output wbx_dat_t           tgt_dat_o,     // write data
   input  logic               tgt_ack_i,     // acknowledge
   input  logic               tgt_err_i,     // error
   input  logic               tgt_rty_i,     // retry
   input  logic               tgt_stall_i,   // back-pressure
   input  wbx_dat_t           tgt_dat_i      // read data
);

   logic val_acc;                            // valid request taken
   logic inval_acc;                          // invalid request taken
   logic tgt_done;                           // target responded
   logic gen_err;                            // generated err pulse
   logic hold_inval;                         // ordering stall

   //-----------------------------------------------------------------------
   // initiator request bundle
   //-----------------------------------------------------------------------
   wbx_req_if #(.TGT_CNT(TGT_CNT)) req_if (.clk_i(clk_i));

   assign req_if.cyc    = itr_cyc_i;
   assign req_if.stb    = itr_stb_i;
   assign req_if.we     = itr_we_i;
   assign req_if.sel    = itr_sel_i;
   assign req_if.adr    = itr_adr_i;
   assign req_if.dat    = itr_dat_i;
   assign req_if.tgtsel = itr_tgtsel_i;

   wbx_req_router #(.TGT_CNT(TGT_CNT)) u_router (
      .req          (req_if),
      .gen_err_i    (gen_err),
      .hold_inval_i (hold_inval),
      .val_acc_o    (val_acc),
      .inval_acc_o  (inval_acc),
      .tgt_done_o   (tgt_done),
      .tgt_cyc_o    (tgt_cyc_o),
      .tgt_stb_o    (tgt_stb_o),
      .tgt_we_o     (tgt_we_o),
      .tgt_sel_o    (tgt_sel_o),
      .tgt_adr_o    (tgt_adr_o),
      .tgt_dat_o    (tgt_dat_o),
      .tgt_ack_i    (tgt_ack_i),
      .tgt_err_i    (tgt_err_i),
      .tgt_rty_i    (tgt_rty_i),
      .tgt_stall_i  (tgt_stall_i),
      .tgt_dat_i    (tgt_dat_i),
      .itr_ack_o    (itr_ack_o),
      .itr_err_o    (itr_err_o),
      .itr_rty_o    (itr_rty_o),
      .itr_stall_o  (itr_stall_o),
      .itr_dat_o    (itr_dat_o)
   );

   wbx_err_fsm u_err_fsm (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .val_acc_i    (val_acc),
      .inval_acc_i  (inval_acc),
      .tgt_done_i   (tgt_done),
      .gen_err_o    (gen_err),
      .hold_inval_o (hold_inval)
   );

endmodule : wbx_error_generator

// File: tb/tb_wbx_error_generator.sv
//--------------------------------------------------------------------------
// Wishbone error generator testbench
// table driven requests against a one-cycle ack target model, with
// in-order response checks, stall counts and a cycle timeout
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module tb_wbx_error_generator
   import wbx_pkg::*;
();

   localparam int NROWS   = 9;               // stimulus table rows
   localparam int TIMEOUT = 20 * NROWS + 8;  // rows plus reset cycles

   logic clk_i, rst_i;
   logic itr_cyc_i, itr_stb_i, itr_we_i, itr_ack_o, itr_err_o, itr_rty_o, itr_stall_o;
   wbx_sel_t itr_sel_i, tgt_sel_o;
   wbx_adr_t itr_adr_i, tgt_adr_o;
   wbx_dat_t itr_dat_i, itr_dat_o, tgt_dat_o, tgt_dat_i;
   logic [3:0] itr_tgtsel_i;
   logic tgt_cyc_o, tgt_stb_o, tgt_we_o, tgt_ack_i, tgt_err_i, tgt_rty_i, tgt_stall_i;

   //-----------------------------------------------------------------------
   // stimulus table, err column set where an error response is expected
   //-----------------------------------------------------------------------
   string      row_name [NROWS] = '{"wr_t0", "rd_t1", "inv_after_rd", "inv_b2b",
                                    "wr_stall2", "rd_stall3", "inv_after_wr",
                                    "rd_multi", "inv_after_multi"};
   logic [3:0] row_tgt  [NROWS] = '{4'b0001, 4'b0010, 4'b0000, 4'b0000, 4'b0100,
                                    4'b1000, 4'b0000, 4'b1010, 4'b0000};
   logic       row_we   [NROWS] = '{1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0};
   int         row_stall[NROWS] = '{0, 0, 0, 0, 2, 3, 0, 1, 0};
   logic       row_err  [NROWS] = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1};
   wbx_adr_t   row_adr  [NROWS];             // address actually driven

   int         row_errs [NROWS+1];           // last entry is the reset test
   int         exp_row[$];                   // accepted rows awaiting response
   int         exp_cyc[$];                   // their accept cycles
   int         cyc_cnt  = 0;
   int         err_cnt  = 0;
   int         pass_cnt = 0;
   int         fail_cnt = 0;
   logic [31:0] lfsr    = 32'h89b0aab0;

   wbx_error_generator #(.TGT_CNT(4)) uut (.*);

   initial
   begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;            // 100 ns period
   end

   always @(posedge clk_i) cyc_cnt <= cyc_cnt + 1;

   // target model, ack one cycle after each accepted strobe
   always @(posedge clk_i)
   begin
      if (rst_i)
      begin
         tgt_ack_i <= 1'b0;
      end
      else
      begin
         tgt_ack_i <= tgt_cyc_o & tgt_stb_o & ~tgt_stall_i;
         tgt_dat_i <= tgt_adr_o ^ 16'h5a5a;  // read data pattern
      end
   end

   //-----------------------------------------------------------------------
   // helpers
   //-----------------------------------------------------------------------
   function automatic logic [31:0] lfsr_bits(input int n);
      logic [31:0] val;
      logic        fb;
      val = '0;
      for (int k = 0; k < n; k++)
      begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];  // x^32+x^22+x^2+x+1
         lfsr = {lfsr[30:0], fb};
         val  = {val[30:0], fb};
      end
      return val;
   endfunction

   // stall cycles follow from target stall, or one pending ack before an invalid
   function automatic int expected_stall(input int i);
      if (!row_err[i])
         return row_stall[i];
      return (i > 0 && !row_err[i-1]) ? 1 : 0;
   endfunction

   task automatic check_value(input int idx, input string what,
                              input logic [31:0] exp, input logic [31:0] act);
      assert (exp === act)
      else
      begin
         $display("Fail %s %s: expected %h, actual %h",
                  (idx == NROWS) ? "reset" : row_name[idx], what, exp, act);
         row_errs[idx]++;
         err_cnt++;
      end
   endtask

   task automatic report_test(input int idx, input string name);
      if (row_errs[idx] == 0)
      begin
         $display("%s: pass", name);
         pass_cnt++;
      end
      else
      begin
         $display("%s: fail, %0d wrong values", name, row_errs[idx]);
         fail_cnt++;
      end
   endtask

   // drive one row, hold it through the stall and log the accept cycle
   task automatic issue_row(input int i);
      int   stall_seen;
      int   stall_left;
      logic accepted;
      logic [31:0] bits;
      wbx_dat_t dat;
      wbx_sel_t sel;
      bits       = lfsr_bits(ADR_WIDTH);
      row_adr[i] = bits[ADR_WIDTH-1:0];
      bits       = lfsr_bits(DAT_WIDTH);
      dat        = bits[DAT_WIDTH-1:0];
      bits       = lfsr_bits(SEL_WIDTH);
      sel        = bits[SEL_WIDTH-1:0];
      stall_seen = 0;
      stall_left = row_stall[i];
      accepted   = 1'b0;
      @(posedge clk_i);
      itr_cyc_i    <= 1'b1;
      itr_stb_i    <= 1'b1;
      itr_we_i     <= row_we[i];
      itr_sel_i    <= sel;
      itr_adr_i    <= row_adr[i];
      itr_dat_i    <= dat;
      itr_tgtsel_i <= row_tgt[i];
      tgt_stall_i  <= (stall_left > 0);
      while (!accepted)
      begin
         @(negedge clk_i);
         if (row_err[i])
            check_value(i, "tgt_stb", 1'b0, tgt_stb_o);  // never forwarded
         if (itr_stall_o)
         begin
            stall_seen++;
            @(posedge clk_i);
            if (stall_left > 0)
               stall_left--;
            tgt_stall_i <= (stall_left > 0);
         end
         else
         begin
            accepted = 1'b1;
            exp_row.push_back(i);
            exp_cyc.push_back(cyc_cnt);
            check_value(i, "tgt_cyc", 1'b1, tgt_cyc_o);  // cycle follows initiator
            if (!row_err[i])
            begin
               check_value(i, "tgt_stb", 1'b1, tgt_stb_o);
               check_value(i, "tgt_we", row_we[i], tgt_we_o);
               check_value(i, "tgt_adr", row_adr[i], tgt_adr_o);
               check_value(i, "tgt_dat", dat, tgt_dat_o);
               check_value(i, "tgt_sel", sel, tgt_sel_o);
            end
         end
      end
      check_value(i, "stall cycles", expected_stall(i), stall_seen);
   endtask

   //-----------------------------------------------------------------------
   // response monitor, strictly in order of acceptance
   //-----------------------------------------------------------------------
   always @(negedge clk_i)
   begin : resp_monitor
      int r;
      int c;
      if (!rst_i && (itr_ack_o || itr_err_o))
      begin
         assert (exp_row.size() != 0)
         else
         begin
            $display("response seen with no request outstanding");
            err_cnt++;
         end
         if (exp_row.size() != 0)
         begin
            r = exp_row.pop_front();
            c = exp_cyc.pop_front();
            check_value(r, "ack", !row_err[r], itr_ack_o);
            check_value(r, "err", row_err[r], itr_err_o);
            check_value(r, "response cycle", c + 1, cyc_cnt);
            if (!row_err[r] && !row_we[r])
               check_value(r, "read data", row_adr[r] ^ 16'h5a5a, itr_dat_o);
            report_test(r, row_name[r]);
         end
      end
      if (!rst_i)
      begin
         assert (!itr_rty_o)
         else
         begin
            $display("retry seen on the initiator bus");
            err_cnt++;
         end
      end
   end

   initial
   begin
      wait (cyc_cnt >= TIMEOUT);
      $display("timeout after %0d cycles, responses still missing", cyc_cnt);
      $display("Test FAILED");
      $finish;
   end

   //-----------------------------------------------------------------------
   // main sequence
   //-----------------------------------------------------------------------
   initial
   begin
      rst_i = 1'b1;
      itr_cyc_i = 1'b0;
      itr_stb_i = 1'b0;
      itr_we_i = 1'b0;
      itr_sel_i = '0;
      itr_adr_i = '0;
      itr_dat_i = '0;
      itr_tgtsel_i = '0;
      tgt_ack_i = 1'b0;
      tgt_err_i = 1'b0;
      tgt_rty_i = 1'b0;
      tgt_stall_i = 1'b0;
      tgt_dat_i = '0;
      for (int k = 0; k <= NROWS; k++)
         row_errs[k] = 0;
      repeat (9)
      begin
         @(negedge clk_i);                   // in reset and just after
         check_value(NROWS, "ack", 1'b0, itr_ack_o);
         check_value(NROWS, "err", 1'b0, itr_err_o);
         check_value(NROWS, "rty", 1'b0, itr_rty_o);
         check_value(NROWS, "tgt_stb", 1'b0, tgt_stb_o);
         if (cyc_cnt == 7)
         begin
            @(posedge clk_i);
            rst_i <= 1'b0;                   // eighth edge still in reset
         end
      end
      report_test(NROWS, "reset");
      for (int i = 0; i < NROWS; i++)
         issue_row(i);
      @(posedge clk_i);
      itr_cyc_i   <= 1'b0;
      itr_stb_i   <= 1'b0;
      tgt_stall_i <= 1'b0;
      while (exp_row.size() != 0)
         @(negedge clk_i);
      repeat (3) @(negedge clk_i);           // catch stray responses
      assert (pass_cnt + fail_cnt == NROWS + 1)
      else
      begin
         $display("only %0d of %0d tests finished", pass_cnt + fail_cnt, NROWS + 1);
         err_cnt++;
      end
      $display("%0d tests passed, %0d failed, %0d errors", pass_cnt, fail_cnt, err_cnt);
      if (err_cnt == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule : tb_wbx_error_generator

// File: sim.f
hdl/wbx_pkg.sv
hdl/wbx_req_if.sv
hdl/wbx_req_router.sv
hdl/wbx_err_fsm.sv
hdl/wbx_error_generator.sv
tb/tb_wbx_error_generator.sv
